// ==== hw/hw_mgr_defines.svh ====
`ifndef HW_MGR_DEFINES_SVH
`define HW_MGR_DEFINES_SVH

// Default sequence limits in clock cycles, sized for a 250 MHz clock

// 10 ms between shutdown force release and the reset pulse
`define HW_MGR_SD_FORCE_DELAY 2500000

// 100 us low pulse on the shutdown reset
`define HW_MGR_SD_RST_PULSE 25000

// 100 ms settle time before the DMA is started
`define HW_MGR_SD_RST_DELAY 25000000

`define HW_MGR_BUF_LOAD_WAIT 250000000   // DAC buffer load timeout
`define HW_MGR_SPI_START_WAIT 250000000  // SPI start timeout

// Sequence counter width
`define HW_MGR_TIMER_W 32

// Boards in the system, one flag bit each in the per-board vectors
`define HW_MGR_NUM_BOARDS 8

`endif

// ==== hw/hw_mgr_pkg.sv ====
`default_nettype none

`include "hw_mgr_defines.svh"

package hw_mgr_pkg;

  // Machine state, also reported in the low nibble of the status word
  typedef enum logic [3:0] {
    IDLE         = 4'd1,
    RELEASE_SD_F = 4'd2,
    PULSE_SD_RST = 4'd3,
    SD_RST_DELAY = 4'd4,
    START_DMA    = 4'd5,
    START_SPI    = 4'd6,
    RUNNING      = 4'd7,
    HALTED       = 4'd8
  } hw_state_t;

  // Status codes, gaps are the retired FIFO and premature-event faults
  typedef enum logic [24:0] {
    STATUS_OK            = 25'd1,
    STATUS_PS_SHUTDOWN   = 25'd2,   // Processor dropped sys_en
    TRIG_LOCKOUT_OOB     = 25'd3,
    CAL_OFFSET_OOB       = 25'd4,
    DAC_DIVIDER_OOB      = 25'd5,
    INTEG_THRESH_AVG_OOB = 25'd6,
    INTEG_WINDOW_OOB     = 25'd7,
    INTEG_EN_OOB         = 25'd8,
    SYS_EN_OOB           = 25'd9,
    LOCK_VIOL            = 25'd10,
    SHUTDOWN_SENSE       = 25'd11,  // Per board
    EXT_SHUTDOWN         = 25'd12,
    DAC_OVER_THRESH      = 25'd13,  // Per board
    ADC_OVER_THRESH      = 25'd14,  // Per board
    DAC_BUF_UNDERFLOW    = 25'd19,  // Per board
    ADC_BUF_OVERFLOW     = 25'd22,  // Per board
    DAC_BUF_FILL_TIMEOUT = 25'd27,
    SPI_START_TIMEOUT    = 25'd28
  } status_code_t;

  // Board index and one-flag-per-board vector
  typedef logic [$clog2(`HW_MGR_NUM_BOARDS)-1:0] board_num_t;
  typedef logic [`HW_MGR_NUM_BOARDS-1:0]         board_mask_t;

  // Which limit the sequence timer compares against
  typedef enum logic [2:0] {
    FORCE_DELAY,
    RST_PULSE,
    RST_DELAY,
    BUF_WAIT,
    SPI_WAIT
  } timer_phase_t;

  typedef logic [`HW_MGR_TIMER_W-1:0] tmr_count_t;

endpackage

`default_nettype wire

// ==== hw/fault_if.sv ====
`default_nettype none

// Encoded fault results, encoder to state machine
interface fault_if;
  import hw_mgr_pkg::*;

  logic         cfg_fault;  // Any config flag set
  status_code_t cfg_code;   // Highest priority config flag
  logic         run_fault;  // Any runtime hardware fault
  status_code_t run_code;
  board_num_t   run_board;  // Lowest set bit of winning vector

  modport encoder (output cfg_fault, cfg_code, run_fault, run_code, run_board);
  modport fsm (input cfg_fault, cfg_code, run_fault, run_code, run_board);

endinterface

`default_nettype wire

// ==== hw/fault_encoder.sv ====
`default_nettype none

`include "hw_mgr_defines.svh"

module fault_encoder (
  // Config out-of-bounds flags
  input wire                        trig_lockout_oob,
  input wire                        cal_offset_oob,
  input wire                        dac_divider_oob,
  input wire                        integ_thresh_avg_oob,
  input wire                        integ_window_oob,
  input wire                        integ_en_oob,
  input wire                        sys_en_oob,
  // Runtime faults
  input wire                        lock_viol,
  input wire                        ext_shutdown,
  input wire hw_mgr_pkg::board_mask_t shutdown_sense,
  input wire hw_mgr_pkg::board_mask_t dac_over_thresh,
  input wire hw_mgr_pkg::board_mask_t adc_over_thresh,
  input wire hw_mgr_pkg::board_mask_t dac_buf_underflow,
  input wire hw_mgr_pkg::board_mask_t adc_buf_overflow,
  fault_if.encoder                  flt
);
  import hw_mgr_pkg::*;

  // Lowest set bit wins, 0 when nothing is set
  function automatic board_num_t lowest_set(input board_mask_t mask);
    board_num_t idx;
    idx = '0;
    for (int i = `HW_MGR_NUM_BOARDS - 1; i >= 0; i--) begin
      if (mask[i]) idx = board_num_t'(i);  // Scan down so bit 0 lands last
    end
    return idx;
  endfunction

  // Config check, priority as listed
  always_comb begin
    flt.cfg_fault = 1'b1;
    if (trig_lockout_oob)          flt.cfg_code = TRIG_LOCKOUT_OOB;
    else if (cal_offset_oob)       flt.cfg_code = CAL_OFFSET_OOB;
    else if (dac_divider_oob)      flt.cfg_code = DAC_DIVIDER_OOB;
    else if (integ_thresh_avg_oob) flt.cfg_code = INTEG_THRESH_AVG_OOB;
    else if (integ_window_oob)     flt.cfg_code = INTEG_WINDOW_OOB;
    else if (integ_en_oob)         flt.cfg_code = INTEG_EN_OOB;
    else if (sys_en_oob)           flt.cfg_code = SYS_EN_OOB;
    else begin
      flt.cfg_fault = 1'b0;
      flt.cfg_code  = STATUS_OK;  // Nothing out of bounds
    end
  end

  // Runtime check, sys_en low is ranked above this in the FSM
  always_comb begin
    flt.run_fault = 1'b1;
    flt.run_board = '0;  // Single-bit faults report board 0
    if (lock_viol) begin
      flt.run_code = LOCK_VIOL;
    end else if (|shutdown_sense) begin
      flt.run_code  = SHUTDOWN_SENSE;
      flt.run_board = lowest_set(shutdown_sense);
    end else if (ext_shutdown) begin
      flt.run_code = EXT_SHUTDOWN;
    end else if (|dac_over_thresh) begin
      flt.run_code  = DAC_OVER_THRESH;
      flt.run_board = lowest_set(dac_over_thresh);
    end else if (|adc_over_thresh) begin
      flt.run_code  = ADC_OVER_THRESH;
      flt.run_board = lowest_set(adc_over_thresh);
    end else if (|dac_buf_underflow) begin
      flt.run_code  = DAC_BUF_UNDERFLOW;
      flt.run_board = lowest_set(dac_buf_underflow);
    end else if (|adc_buf_overflow) begin
      flt.run_code  = ADC_BUF_OVERFLOW;
      flt.run_board = lowest_set(adc_buf_overflow);
    end else begin
      flt.run_fault = 1'b0;
      flt.run_code  = STATUS_OK;
    end
  end

endmodule

`default_nettype wire

// ==== hw/seq_timer.sv ====
`default_nettype none

`include "hw_mgr_defines.svh"

module seq_timer #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = `HW_MGR_SD_FORCE_DELAY,
  parameter int unsigned SHUTDOWN_RESET_PULSE = `HW_MGR_SD_RST_PULSE,
  parameter int unsigned SHUTDOWN_RESET_DELAY = `HW_MGR_SD_RST_DELAY,
  parameter int unsigned BUF_LOAD_WAIT        = `HW_MGR_BUF_LOAD_WAIT,
  parameter int unsigned SPI_START_WAIT       = `HW_MGR_SPI_START_WAIT
) (
  input wire                          clk,
  input wire                          rst,
  input wire                          tmr_clear,  // Zero the count, one cycle
  input wire hw_mgr_pkg::timer_phase_t tmr_phase,
  output logic                        tmr_expired
);
  import hw_mgr_pkg::*;

  tmr_count_t count;
  tmr_count_t limit;  // Limit of the active phase

  always_comb begin
    case (tmr_phase)
      FORCE_DELAY: limit = tmr_count_t'(SHUTDOWN_FORCE_DELAY);
      RST_PULSE:   limit = tmr_count_t'(SHUTDOWN_RESET_PULSE);
      RST_DELAY:   limit = tmr_count_t'(SHUTDOWN_RESET_DELAY);
      BUF_WAIT:    limit = tmr_count_t'(BUF_LOAD_WAIT);
      SPI_WAIT:    limit = tmr_count_t'(SPI_START_WAIT);
      default:     limit = tmr_count_t'(SHUTDOWN_FORCE_DELAY);
    endcase
  end

  assign tmr_expired = (count >= limit);

  // Counts every cycle, parks at the limit so it never wraps
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (tmr_clear) begin
      count <= '0;
    end else if (!tmr_expired) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/hw_mgr_fsm.sv ====
`default_nettype none

module hw_mgr_fsm (
  input wire                           clk,
  input wire                           rst,
  input wire                           sys_en,
  input wire                           dac_buf_loaded,
  input wire                           spi_running,
  fault_if.fsm                         flt,
  // Sequence timer
  output logic                         tmr_clear,
  output hw_mgr_pkg::timer_phase_t     tmr_phase,
  input wire                           tmr_expired,
  // Control outputs, all registered
  output logic                         sys_rst,
  output logic                         unlock_cfg,
  output logic                         dma_en,
  output logic                         spi_en,
  output logic                         trig_en,
  output logic                         n_shutdown_force,
  output logic                         n_shutdown_rst,
  output logic                         ps_interrupt,
  output logic [31:0]                  status_word
);
  import hw_mgr_pkg::*;

  hw_state_t    state, state_nxt;
  status_code_t status_code, code_nxt;
  board_num_t   board_num, board_nxt;
  logic sys_rst_nxt, unlock_nxt, dma_nxt, spi_nxt, trig_nxt;
  logic force_nxt, sd_rst_nxt;
  logic irq_nxt;

  assign status_word = {board_num, status_code, state};

  // Timer limit follows the state
  always_comb begin
    case (state)
      RELEASE_SD_F: tmr_phase = FORCE_DELAY;
      PULSE_SD_RST: tmr_phase = RST_PULSE;
      SD_RST_DELAY: tmr_phase = RST_DELAY;
      START_DMA:    tmr_phase = BUF_WAIT;
      START_SPI:    tmr_phase = SPI_WAIT;
      default:      tmr_phase = FORCE_DELAY;
    endcase
  end

  // Next state and next output values
  always_comb begin
    state_nxt   = state;
    code_nxt    = status_code;
    board_nxt   = board_num;
    sys_rst_nxt = sys_rst;
    unlock_nxt  = unlock_cfg;
    dma_nxt     = dma_en;
    spi_nxt     = spi_en;
    trig_nxt    = trig_en;
    force_nxt   = n_shutdown_force;
    sd_rst_nxt  = n_shutdown_rst;
    case (state)
      IDLE: begin
        if (sys_en) begin
          if (flt.cfg_fault) begin
            state_nxt = HALTED;  // Outputs left as they are
            code_nxt  = flt.cfg_code;
          end else begin
            state_nxt   = RELEASE_SD_F;
            sys_rst_nxt = 1'b0;
            unlock_nxt  = 1'b0;  // Lock config for the run
            force_nxt   = 1'b1;
          end
        end
      end
      RELEASE_SD_F: begin
        if (tmr_expired) begin
          state_nxt  = PULSE_SD_RST;
          sd_rst_nxt = 1'b0;  // Start of reset pulse
        end
      end
      PULSE_SD_RST: begin
        if (tmr_expired) begin
          state_nxt  = SD_RST_DELAY;
          sd_rst_nxt = 1'b1;
        end
      end
      SD_RST_DELAY: begin
        if (tmr_expired) begin
          state_nxt = START_DMA;
          dma_nxt   = 1'b1;
        end
      end
      START_DMA: begin
        if (dac_buf_loaded) begin
          state_nxt = START_SPI;
          spi_nxt   = 1'b1;
        end else if (tmr_expired) begin
          state_nxt   = HALTED;  // Buffer never filled
          code_nxt    = DAC_BUF_FILL_TIMEOUT;
          sys_rst_nxt = 1'b1;
          force_nxt   = 1'b0;
          dma_nxt     = 1'b0;
        end
      end
      START_SPI: begin
        if (spi_running) begin
          state_nxt = RUNNING;
          trig_nxt  = 1'b1;
        end else if (tmr_expired) begin
          state_nxt   = HALTED;
          code_nxt    = SPI_START_TIMEOUT;
          sys_rst_nxt = 1'b1;
          force_nxt   = 1'b0;
          dma_nxt     = 1'b0;
          spi_nxt     = 1'b0;
        end
      end
      RUNNING: begin
        if (!sys_en || flt.run_fault) begin
          state_nxt   = HALTED;
          sys_rst_nxt = 1'b1;
          force_nxt   = 1'b0;
          dma_nxt     = 1'b0;
          spi_nxt     = 1'b0;
          trig_nxt    = 1'b0;
          if (!sys_en) begin
            code_nxt = STATUS_PS_SHUTDOWN;  // Processor request wins over hw faults
          end else begin
            code_nxt  = flt.run_code;
            board_nxt = flt.run_board;
          end
        end
      end
      HALTED: begin
        // Hold the code until the processor drops sys_en
        if (!sys_en) begin
          state_nxt  = IDLE;
          code_nxt   = STATUS_OK;
          board_nxt  = '0;
          unlock_nxt = 1'b1;
        end
      end
      default: state_nxt = IDLE;  // Illegal encoding recovery
    endcase
  end

  // Every state change restarts the timer
  assign tmr_clear = (state_nxt != state);
  assign irq_nxt   = tmr_clear && (state_nxt == RUNNING || state_nxt == HALTED);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state            <= IDLE;
      status_code      <= STATUS_OK;
      board_num        <= '0;
      sys_rst          <= 1'b1;
      unlock_cfg       <= 1'b1;
      dma_en           <= 1'b0;
      spi_en           <= 1'b0;
      trig_en          <= 1'b0;
      n_shutdown_force <= 1'b0;  // Boards held in shutdown
      n_shutdown_rst   <= 1'b1;
      ps_interrupt     <= 1'b0;
    end else begin
      state            <= state_nxt;
      status_code      <= code_nxt;
      board_num        <= board_nxt;
      sys_rst          <= sys_rst_nxt;
      unlock_cfg       <= unlock_nxt;
      dma_en           <= dma_nxt;
      spi_en           <= spi_nxt;
      trig_en          <= trig_nxt;
      n_shutdown_force <= force_nxt;
      n_shutdown_rst   <= sd_rst_nxt;
      ps_interrupt     <= irq_nxt;  // Single cycle per entry
    end
  end

endmodule

`default_nettype wire

// ==== hw/hw_manager.sv ====
`default_nettype none

`include "hw_mgr_defines.svh"

module hw_manager #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = `HW_MGR_SD_FORCE_DELAY,
  parameter int unsigned SHUTDOWN_RESET_PULSE = `HW_MGR_SD_RST_PULSE,
  parameter int unsigned SHUTDOWN_RESET_DELAY = `HW_MGR_SD_RST_DELAY,
  parameter int unsigned BUF_LOAD_WAIT        = `HW_MGR_BUF_LOAD_WAIT,
  parameter int unsigned SPI_START_WAIT       = `HW_MGR_SPI_START_WAIT
) (
  input wire                          clk,
  input wire                          rst,
  input wire                          sys_en,
  input wire                          dac_buf_loaded,
  input wire                          spi_running,
  input wire                          ext_shutdown,
  input wire                          trig_lockout_oob,
  input wire                          cal_offset_oob,
  input wire                          dac_divider_oob,
  input wire                          integ_thresh_avg_oob,
  input wire                          integ_window_oob,
  input wire                          integ_en_oob,
  input wire                          sys_en_oob,
  input wire                          lock_viol,
  input wire hw_mgr_pkg::board_mask_t shutdown_sense,
  input wire hw_mgr_pkg::board_mask_t dac_over_thresh,
  input wire hw_mgr_pkg::board_mask_t adc_over_thresh,
  input wire hw_mgr_pkg::board_mask_t dac_buf_underflow,
  input wire hw_mgr_pkg::board_mask_t adc_buf_overflow,
  output wire                         sys_rst,
  output wire                         unlock_cfg,
  output wire                         dma_en,
  output wire                         spi_en,
  output wire                         trig_en,
  output wire                         n_shutdown_force,
  output wire                         n_shutdown_rst,
  output wire                         ps_interrupt,
  output wire [31:0]                  status_word  // {board, code, state}
);
  import hw_mgr_pkg::*;

  fault_if flt_if ();

  logic         tmr_clear;
  timer_phase_t tmr_phase;
  logic         tmr_expired;

  fault_encoder fault_encoder_inst (
    .trig_lockout_oob     (trig_lockout_oob),
    .cal_offset_oob       (cal_offset_oob),
    .dac_divider_oob      (dac_divider_oob),
    .integ_thresh_avg_oob (integ_thresh_avg_oob),
    .integ_window_oob     (integ_window_oob),
    .integ_en_oob         (integ_en_oob),
    .sys_en_oob           (sys_en_oob),
    .lock_viol            (lock_viol),
    .ext_shutdown         (ext_shutdown),
    .shutdown_sense       (shutdown_sense),
    .dac_over_thresh      (dac_over_thresh),
    .adc_over_thresh      (adc_over_thresh),
    .dac_buf_underflow    (dac_buf_underflow),
    .adc_buf_overflow     (adc_buf_overflow),
    .flt                  (flt_if.encoder)
  );

  seq_timer #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .BUF_LOAD_WAIT        (BUF_LOAD_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) seq_timer_inst (
    .clk         (clk),
    .rst         (rst),
    .tmr_clear   (tmr_clear),
    .tmr_phase   (tmr_phase),
    .tmr_expired (tmr_expired)
  );

  hw_mgr_fsm hw_mgr_fsm_inst (
    .clk              (clk),
    .rst              (rst),
    .sys_en           (sys_en),
    .dac_buf_loaded   (dac_buf_loaded),
    .spi_running      (spi_running),
    .flt              (flt_if.fsm),
    .tmr_clear        (tmr_clear),
    .tmr_phase        (tmr_phase),
    .tmr_expired      (tmr_expired),
    .sys_rst          (sys_rst),
    .unlock_cfg       (unlock_cfg),
    .dma_en           (dma_en),
    .spi_en           (spi_en),
    .trig_en          (trig_en),
    .n_shutdown_force (n_shutdown_force),
    .n_shutdown_rst   (n_shutdown_rst),
    .ps_interrupt     (ps_interrupt),
    .status_word      (status_word)
  );

endmodule

`default_nettype wire

// ==== verif/hw_mgr_tb_ref.svh ====
`ifndef HW_MGR_TB_REF_SVH
`define HW_MGR_TB_REF_SVH

// State values as seen in status_word[3:0]
localparam int ST_IDLE         = 1;
localparam int ST_RELEASE_SD_F = 2;
localparam int ST_PULSE_SD_RST = 3;
localparam int ST_SD_RST_DELAY = 4;
localparam int ST_START_DMA    = 5;
localparam int ST_START_SPI    = 6;
localparam int ST_RUNNING      = 7;
localparam int ST_HALTED       = 8;

// Status codes
localparam int C_OK           = 1;
localparam int C_PS_SHUTDOWN  = 2;
localparam int C_TRIG_LOCKOUT = 3;   // Seven config codes run 3 to 9
localparam int C_LOCK_VIOL    = 10;
localparam int C_SD_SENSE     = 11;
localparam int C_EXT_SD       = 12;
localparam int C_DAC_OT       = 13;
localparam int C_ADC_OT       = 14;
localparam int C_DAC_UF       = 19;
localparam int C_ADC_OF       = 22;
localparam int C_BUF_TIMEOUT  = 27;
localparam int C_SPI_TIMEOUT  = 28;

// Flag bit 0 is trig_lockout_oob, bit 6 sys_en_oob
function automatic int cfg_code_ref(input logic [6:0] flags);
  int code;
  int i;
  code = C_OK;
  for (i = 6; i >= 0; i--) begin
    if (flags[i]) code = C_TRIG_LOCKOUT + i;  // Lower bit outranks
  end
  return code;
endfunction

function automatic int run_code_ref(input logic lock, input logic [7:0] sense,
                                    input logic ext, input logic [7:0] dac_ot,
                                    input logic [7:0] adc_ot, input logic [7:0] dac_uf,
                                    input logic [7:0] adc_of);
  int code;
  code = C_OK;
  if (lock) code = C_LOCK_VIOL;
  else if (sense != 8'h00) code = C_SD_SENSE;
  else if (ext) code = C_EXT_SD;
  else if (dac_ot != 8'h00) code = C_DAC_OT;
  else if (adc_ot != 8'h00) code = C_ADC_OT;
  else if (dac_uf != 8'h00) code = C_DAC_UF;
  else if (adc_of != 8'h00) code = C_ADC_OF;
  return code;
endfunction

// Board vector of the winning fault or zero for single-bit faults
function automatic logic [7:0] win_mask_ref(input logic lock, input logic [7:0] sense,
                                            input logic ext, input logic [7:0] dac_ot,
                                            input logic [7:0] adc_ot, input logic [7:0] dac_uf,
                                            input logic [7:0] adc_of);
  logic [7:0] mask;
  mask = 8'h00;
  if (lock) mask = 8'h00;
  else if (sense != 8'h00) mask = sense;
  else if (ext) mask = 8'h00;
  else if (dac_ot != 8'h00) mask = dac_ot;
  else if (adc_ot != 8'h00) mask = adc_ot;
  else if (dac_uf != 8'h00) mask = dac_uf;
  else mask = adc_of;
  return mask;
endfunction

// Search upward from board 0 for the first flag
function automatic int lowest_bit(input logic [7:0] mask);
  int idx;
  int i;
  idx = 0;
  for (i = 0; i < 8; i++) begin
    if (mask[i]) begin
      idx = i;
      break;  // First hit is the lowest board
    end
  end
  return idx;
endfunction

// Board in 31:29, code in 28:4, state in 3:0
function automatic logic [31:0] status_word_ref(input int st, input int code, input int board);
  return {board[2:0], code[24:0], st[3:0]};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// ==== verif/hw_manager_tb.sv ====
`default_nettype none

module hw_manager_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int F_LIM = 20;
  localparam int P_LIM = 5;
  localparam int R_LIM = 30;
  localparam int B_LIM = 40;
  localparam int S_LIM = 40;
  localparam int WAIT_MAX = 200;  // Cycle bound of every wait loop

  // Control vector order: sys_rst unlock_cfg dma spi trig force sd_rst irq
  localparam logic [7:0] CTRL_IDLE = 8'b1100_0010;
  localparam logic [7:0] CTRL_HALT = 8'b1000_0011;  // Halt from a running stage

  logic clk, rst, sys_en, dac_buf_loaded, spi_running, ext_shutdown, lock_viol;
  logic trig_lockout_oob, cal_offset_oob, dac_divider_oob, integ_thresh_avg_oob;
  logic integ_window_oob, integ_en_oob, sys_en_oob;
  logic [7:0] shutdown_sense, dac_over_thresh, adc_over_thresh;
  logic [7:0] dac_buf_underflow, adc_buf_overflow;
  wire sys_rst, unlock_cfg, dma_en, spi_en, trig_en;
  wire n_shutdown_force, n_shutdown_rst, ps_interrupt;
  wire [31:0] status_word;
  wire [7:0] ctrl_bus;

  // Expected values, posted by the stimulus and read by the compare process
  int exp_state, exp_code, exp_board;
  logic [7:0] exp_ctrl;
  int chk_seq, seen_seq, check_count, value_errors, timing_errors, timeouts;
  logic [31:0] rnd_state;

  `include "hw_mgr_tb_ref.svh"

  assign ctrl_bus = {sys_rst, unlock_cfg, dma_en, spi_en, trig_en,
                     n_shutdown_force, n_shutdown_rst, ps_interrupt};

  hw_manager #(
    .SHUTDOWN_FORCE_DELAY (F_LIM),
    .SHUTDOWN_RESET_PULSE (P_LIM),
    .SHUTDOWN_RESET_DELAY (R_LIM),
    .BUF_LOAD_WAIT        (B_LIM),
    .SPI_START_WAIT       (S_LIM)
  ) hw_manager_inst (
    .clk (clk), .rst (rst), .sys_en (sys_en),
    .dac_buf_loaded (dac_buf_loaded), .spi_running (spi_running),
    .ext_shutdown (ext_shutdown), .trig_lockout_oob (trig_lockout_oob),
    .cal_offset_oob (cal_offset_oob), .dac_divider_oob (dac_divider_oob),
    .integ_thresh_avg_oob (integ_thresh_avg_oob), .integ_window_oob (integ_window_oob),
    .integ_en_oob (integ_en_oob), .sys_en_oob (sys_en_oob), .lock_viol (lock_viol),
    .shutdown_sense (shutdown_sense), .dac_over_thresh (dac_over_thresh),
    .adc_over_thresh (adc_over_thresh), .dac_buf_underflow (dac_buf_underflow),
    .adc_buf_overflow (adc_buf_overflow),
    .sys_rst (sys_rst), .unlock_cfg (unlock_cfg), .dma_en (dma_en),
    .spi_en (spi_en), .trig_en (trig_en), .n_shutdown_force (n_shutdown_force),
    .n_shutdown_rst (n_shutdown_rst), .ps_interrupt (ps_interrupt),
    .status_word (status_word)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Compare at the falling edge, outputs settled since the rising edge
  always @(negedge clk) begin : compare
    logic [31:0] exp_word;
    if (chk_seq != seen_seq) begin
      seen_seq = chk_seq;
      check_count++;
      exp_word = status_word_ref(exp_state, exp_code, exp_board);
      if (status_word !== exp_word) begin
        value_errors++;
        $display("** Error at %0t: status_word %h, expected %h", $time, status_word, exp_word);
      end
      if (ctrl_bus !== exp_ctrl) begin
        value_errors++;
        $display("** Error at %0t: controls %b, expected %b", $time, ctrl_bus, exp_ctrl);
      end
    end
  end

  // Next rising edge plus drive delay, also the sample point
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic expect_out(input int st, input int code, input int board,
                            input logic [7:0] ctrl);
    exp_state = st;
    exp_code  = code;
    exp_board = board;
    exp_ctrl  = ctrl;
    chk_seq++;
  endtask

  // Counts edges until a control bit reaches val, then checks the count
  task automatic wait_ctrl(input int idx, input logic val, input int exp_n, input string name);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (ctrl_bus[idx] !== val && n < WAIT_MAX);
    if (ctrl_bus[idx] !== val) begin
      timeouts++;
      $display("Timeout at %0t: %s not seen within %0d cycles", $time, name, WAIT_MAX);
    end else if (n != exp_n) begin
      timing_errors++;
      $display("** Error at %0t: %s after %0d cycles, expected %0d", $time, name, n, exp_n);
    end
  endtask

  task automatic clear_faults();
    {sys_en_oob, integ_en_oob, integ_window_oob, integ_thresh_avg_oob} = 4'h0;
    {dac_divider_oob, cal_offset_oob, trig_lockout_oob} = 3'h0;
    lock_viol         = 1'b0;
    ext_shutdown      = 1'b0;
    shutdown_sense    = 8'h00;
    dac_over_thresh   = 8'h00;
    adc_over_thresh   = 8'h00;
    dac_buf_underflow = 8'h00;
    adc_buf_overflow  = 8'h00;
  endtask

  // About one vector in four carries a fault
  function automatic logic [7:0] sparse_mask(input logic [31:0] w);
    return (w[1:0] == 2'b00) ? w[15:8] : 8'h00;
  endfunction

  task automatic drive_run_faults();
    logic [31:0] r;
    rnd_state = xorshift32(rnd_state);
    r = rnd_state;
    lock_viol    = (r[3:0] == 4'd0);  // Rare so lower ranks get a turn
    ext_shutdown = (r[7:4] < 4'd4);
    rnd_state = xorshift32(rnd_state);
    shutdown_sense = sparse_mask(rnd_state);
    rnd_state = xorshift32(rnd_state);
    dac_over_thresh = sparse_mask(rnd_state);
    rnd_state = xorshift32(rnd_state);
    adc_over_thresh = sparse_mask(rnd_state);
    rnd_state = xorshift32(rnd_state);
    dac_buf_underflow = sparse_mask(rnd_state);
    rnd_state = xorshift32(rnd_state);
    adc_buf_overflow = sparse_mask(rnd_state);
    if (!lock_viol && !ext_shutdown && (shutdown_sense | dac_over_thresh | adc_over_thresh
        | dac_buf_underflow | adc_buf_overflow) == 8'h00) begin
      adc_buf_overflow = 8'h01 << r[10:8];  // Always at least one fault
    end
  endtask

  task automatic return_to_idle();
    sys_en         = 1'b0;
    dac_buf_loaded = 1'b0;
    spi_running    = 1'b0;
    clear_faults();
    step();
    expect_out(ST_IDLE, C_OK, 0, CTRL_IDLE);  // Config unlocked again
  endtask

  // Power-up with optional missing buffer load or SPI start
  task automatic power_up(input logic load, input logic run);
    sys_en = 1'b1;
    wait_ctrl(2, 1'b1, 1, "n_shutdown_force rise");
    expect_out(ST_RELEASE_SD_F, C_OK, 0, 8'b0000_0110);
    wait_ctrl(1, 1'b0, F_LIM + 1, "n_shutdown_rst fall");
    expect_out(ST_PULSE_SD_RST, C_OK, 0, 8'b0000_0100);
    wait_ctrl(1, 1'b1, P_LIM + 1, "n_shutdown_rst rise");
    expect_out(ST_SD_RST_DELAY, C_OK, 0, 8'b0000_0110);
    wait_ctrl(5, 1'b1, R_LIM + 1, "dma_en rise");
    expect_out(ST_START_DMA, C_OK, 0, 8'b0010_0110);
    if (!load) begin
      wait_ctrl(0, 1'b1, B_LIM + 1, "halt on buffer load timeout");
      expect_out(ST_HALTED, C_BUF_TIMEOUT, 0, CTRL_HALT);
    end else begin
      dac_buf_loaded = 1'b1;
      wait_ctrl(4, 1'b1, 1, "spi_en rise");
      expect_out(ST_START_SPI, C_OK, 0, 8'b0011_0110);
      if (!run) begin
        wait_ctrl(0, 1'b1, S_LIM + 1, "halt on SPI start timeout");
        expect_out(ST_HALTED, C_SPI_TIMEOUT, 0, CTRL_HALT);
      end else begin
        spi_running = 1'b1;
        wait_ctrl(3, 1'b1, 1, "trig_en rise");
        expect_out(ST_RUNNING, C_OK, 0, 8'b0011_1111);
        step();
        expect_out(ST_RUNNING, C_OK, 0, 8'b0011_1110);  // Interrupt gone
      end
    end
  endtask

  initial begin : stimulus
    int iter;
    logic [31:0] r;
    logic [6:0] flags;
    clk = 1'b0;
    rst = 1'b1;
    sys_en = 1'b0;
    dac_buf_loaded = 1'b0;
    spi_running = 1'b0;
    clear_faults();
    rnd_state = 32'h2f1a;
    {chk_seq, seen_seq, check_count} = {32'd0, 32'd0, 32'd0};
    {value_errors, timing_errors, timeouts} = {32'd0, 32'd0, 32'd0};
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    expect_out(ST_IDLE, C_OK, 0, CTRL_IDLE);  // Reset values

    // Full power-up, then sys_en low with hardware faults also present
    step();
    power_up(1'b1, 1'b1);
    drive_run_faults();
    sys_en = 1'b0;
    wait_ctrl(0, 1'b1, 1, "interrupt on processor shutdown");
    expect_out(ST_HALTED, C_PS_SHUTDOWN, 0, CTRL_HALT);
    return_to_idle();

    // Config flags at enable, outputs stay as in IDLE
    for (iter = 0; iter < 8; iter++) begin
      rnd_state = xorshift32(rnd_state);
      r = rnd_state;
      flags = r[6:0] & r[22:16];
      if (flags == 7'h00) flags = 7'h01 << (r[10:8] % 3'd7);
      {sys_en_oob, integ_en_oob, integ_window_oob, integ_thresh_avg_oob,
       dac_divider_oob, cal_offset_oob, trig_lockout_oob} = flags;
      sys_en = 1'b1;
      wait_ctrl(0, 1'b1, 1, "interrupt on config halt");
      expect_out(ST_HALTED, cfg_code_ref(flags), 0, 8'b1100_0011);
      step();
      expect_out(ST_HALTED, cfg_code_ref(flags), 0, CTRL_IDLE);
      return_to_idle();
    end

    // Runtime faults while RUNNING
    for (iter = 0; iter < 6; iter++) begin
      power_up(1'b1, 1'b1);
      drive_run_faults();
      wait_ctrl(0, 1'b1, 1, "interrupt on runtime halt");
      expect_out(ST_HALTED,
                 run_code_ref(lock_viol, shutdown_sense, ext_shutdown, dac_over_thresh,
                              adc_over_thresh, dac_buf_underflow, adc_buf_overflow),
                 lowest_bit(win_mask_ref(lock_viol, shutdown_sense, ext_shutdown,
                                         dac_over_thresh, adc_over_thresh,
                                         dac_buf_underflow, adc_buf_overflow)),
                 CTRL_HALT);
      return_to_idle();
    end

    // Missing buffer load, then missing SPI start
    power_up(1'b0, 1'b0);
    return_to_idle();
    power_up(1'b1, 1'b0);
    return_to_idle();
    step();  // Let the last compare run

    $display("Checks %0d, value errors %0d, timing errors %0d, timeouts %0d",
             check_count, value_errors, timing_errors, timeouts);
    if (value_errors == 0 && timing_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
+incdir+verif
hw/hw_mgr_pkg.sv
hw/fault_if.sv
hw/fault_encoder.sv
hw/seq_timer.sv
hw/hw_mgr_fsm.sv
hw/hw_manager.sv
verif/hw_manager_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hw_manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module hw_manager_tb -f all.f -o Vhw_manager_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vhw_manager_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
